// File: design/prbs_pkg.sv
/* Shared PRBS15 constants, vector types, the sync state enum and the byte and
   status structs. Imported by every module of the pattern subsystem. */
`default_nettype none

package prbs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Polynomial x^15 + x^14 + 1

    // Degree, also the first tap
    localparam int unsigned prbs_len = 15;
    // Second tap
    localparam int unsigned prbs_tap = 14;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types

    // One byte on the wire, MSB is sent first
    typedef logic [7:0] byte_t;

    // Last fifteen sequence bits, newest in bit 0
    typedef logic [prbs_len-1:0] prbs_state_t;

    // Errored byte count
    typedef logic [15:0] err_count_t;

    // Receive alignment state
    typedef enum logic [1:0] {
        hunt = 2'd0,
        lock = 2'd1
    } sync_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Grouped signals

    // Received byte with its strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } rx_byte_t;

    // Transmitted byte with its strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } tx_byte_t;

    // Monitor results
    typedef struct packed {
        logic       in_sync;
        logic       byte_err;
        err_count_t err_count;
    } rx_status_t;

endpackage

`default_nettype wire

// File: design/prbs_gen.sv
/* Byte-wide PRBS15 pattern source for the transmit side. One byte per enabled
   cycle, registered, with an optional bit 0 flip on a single byte. */
`timescale 1ns/1ps
`default_nettype none

module prbs_gen import prbs_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     tx_enable,
    input  wire logic     inject_error,
    output tx_byte_t      tx
);

    // Sequence state, starts from all ones
    prbs_state_t gen_state;
    // State and byte after eight more bits
    prbs_state_t step_state;
    byte_t       step_byte;
    // Injection request waiting for an enabled cycle
    logic        inject_pending;
    logic        inject_now;
    // Output registers
    logic        tx_valid_q;
    byte_t       tx_data_q;

    ////////////////////////////////////////////////////////////////////////////
    // Eight bit steps, MSB of the byte comes out first

    always_comb begin
        step_state = gen_state;
        for (int i = 7; i >= 0; i--) begin
            // New bit from taps 15 and 14
            step_byte[i] = step_state[prbs_len-1] ^ step_state[prbs_tap-1];
            step_state   = {step_state[prbs_len-2:0], step_byte[i]};
        end
    end

    // Request from this cycle or one left over from an idle cycle
    assign inject_now = inject_error | inject_pending;

    ////////////////////////////////////////////////////////////////////////////
    // Control registers

    always_ff @(posedge clk) begin
        if (reset) begin
            gen_state      <= '1;
            tx_valid_q     <= 1'b0;
            inject_pending <= 1'b0;
        end else begin
            tx_valid_q <= tx_enable;
            if (tx_enable) begin
                gen_state      <= step_state;
                // Consumed by this byte
                inject_pending <= 1'b0;
            end else if (inject_error) begin
                inject_pending <= 1'b1;
            end
        end
    end

    // Payload, flip only affects the wire, never the state
    always_ff @(posedge clk) begin
        if (tx_enable) begin
            tx_data_q <= step_byte ^ byte_t'(inject_now);
        end
    end

    assign tx = '{valid: tx_valid_q, data: tx_data_q};

endmodule

`default_nettype wire

// File: design/prbs_check.sv
/* Combinational PRBS15 byte checker. Shifts the received bits into the
   expected state MSB first and flags any bit the taps did not predict. */
`timescale 1ns/1ps
`default_nettype none

module prbs_check import prbs_pkg::*; (
    input  wire rx_byte_t    rx,
    input  wire prbs_state_t expected,
    output prbs_state_t      next_state,
    output logic             mismatch
);

    // Per-bit prediction error, index matches the data bit
    byte_t       bit_err;
    // Running state while walking the byte
    prbs_state_t walk_state;
    // Old state holds no sequence at all
    logic        state_zero;

    ////////////////////////////////////////////////////////////////////////////
    // Bit walk

    always_comb begin
        walk_state = expected;
        for (int i = 7; i >= 0; i--) begin
            // Prediction from the state before this bit
            bit_err[i] = rx.data[i] ^ walk_state[prbs_len-1] ^ walk_state[prbs_tap-1];
            // Received bit always enters, good or bad
            walk_state = {walk_state[prbs_len-2:0], rx.data[i]};
        end
    end

    // Self-synchronizing, the state follows the line
    assign next_state = walk_state;

    ////////////////////////////////////////////////////////////////////////////
    // Error flag

    // All-zero state locks up the LFSR, so it is an error too
    assign state_zero = (expected == '0);

    // Only meaningful on a valid byte
    assign mismatch = rx.valid & ((|bit_err) | state_zero);

endmodule

`default_nettype wire

// File: design/prbs_sync_fsm.sv
/* Receive side state holder and hunt/lock FSM. Keeps the expected PRBS state,
   counts good and bad byte runs and flags errors one cycle after the byte. */
`timescale 1ns/1ps
`default_nettype none

module prbs_sync_fsm import prbs_pkg::*; #(
    parameter int unsigned sync_count = 4,
    parameter int unsigned loss_count = 3
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire rx_byte_t    rx,
    input  wire prbs_state_t next_state,
    input  wire logic        mismatch,
    output prbs_state_t      expected,
    output logic             in_sync,
    output logic             byte_err,
    output logic             count_enable
);

    // Run counter must hold the larger threshold
    localparam int unsigned run_max = (sync_count > loss_count) ? sync_count : loss_count;
    localparam int unsigned run_w   = $clog2(run_max + 1);

    sync_state_t      state;
    logic [run_w-1:0] run_cnt;
    // Last byte of a run
    logic             sync_done;
    logic             loss_done;

    assign sync_done = (run_cnt == run_w'(sync_count - 1));
    assign loss_done = (run_cnt == run_w'(loss_count - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Expected state, loaded on every valid byte

    always_ff @(posedge clk) begin
        if (reset) begin
            expected <= '0;
        end else if (rx.valid) begin
            expected <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hunt/lock FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= hunt;
            run_cnt <= '0;
        end else if (rx.valid) begin
            case (state)
                hunt: begin
                    // Good run towards lock
                    if (mismatch) begin
                        run_cnt <= '0;
                    end else if (sync_done) begin
                        state   <= lock;
                        run_cnt <= '0;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                lock: begin
                    // Bad run towards hunt
                    if (!mismatch) begin
                        run_cnt <= '0;
                    end else if (loss_done) begin
                        state   <= hunt;
                        run_cnt <= '0;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                default: begin
                    state   <= hunt;
                    run_cnt <= '0;
                end
            endcase
        end
    end

    assign in_sync = (state == lock);

    ////////////////////////////////////////////////////////////////////////////
    // Error pulses

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_err     <= 1'b0;
            count_enable <= 1'b0;
        end else begin
            byte_err     <= mismatch;
            // Only errors seen while locked are counted
            count_enable <= mismatch & (state == lock);
        end
    end

endmodule

`default_nettype wire

// File: design/prbs_err_counter.sv
/* Saturating errored byte counter for the receive monitor. Steps on each
   count_enable pulse and is zeroed by clear_count. */
`timescale 1ns/1ps
`default_nettype none

module prbs_err_counter import prbs_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic count_enable,
    input  wire logic clear_count,
    output err_count_t err_count
);

    // Count register
    err_count_t count_q;
    // Top value reached, hold there
    logic       count_full;

    ////////////////////////////////////////////////////////////////////////////
    // Saturation detect

    assign count_full = &count_q;

    ////////////////////////////////////////////////////////////////////////////
    // Counter

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (clear_count) begin
            // Clear beats a same-cycle increment
            count_q <= '0;
        end else if (count_enable && !count_full) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Straight from the register
    assign err_count = count_q;

endmodule

`default_nettype wire

// File: design/prbs_mon_top.sv
/* PRBS15 test-pattern subsystem top. Generator drives tx; checker, sync FSM
   and error counter watch rx and report through status. */
`timescale 1ns/1ps
`default_nettype none

module prbs_mon_top import prbs_pkg::*; #(
    parameter int unsigned sync_count = 4,
    parameter int unsigned loss_count = 3
) (
    input  wire logic     clk,
    input  wire logic     reset,
    // Transmit side
    input  wire logic     tx_enable,
    input  wire logic     inject_error,
    output tx_byte_t      tx,
    // Receive side
    input  wire rx_byte_t rx,
    input  wire logic     clear_count,
    output rx_status_t    status
);

    // Checker to FSM
    prbs_state_t expected;
    prbs_state_t next_state;
    logic        mismatch;
    // FSM outputs
    logic        in_sync;
    logic        byte_err;
    logic        count_enable;
    // Counter output
    err_count_t  err_count;

    ////////////////////////////////////////////////////////////////////////////
    // Transmit

    prbs_gen u_gen (
        .clk          (clk),
        .reset        (reset),
        .tx_enable    (tx_enable),
        .inject_error (inject_error),
        .tx           (tx)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Receive

    // Pure logic, state lives in the FSM
    prbs_check u_check (
        .rx         (rx),
        .expected   (expected),
        .next_state (next_state),
        .mismatch   (mismatch)
    );

    prbs_sync_fsm #(
        .sync_count (sync_count),
        .loss_count (loss_count)
    ) u_sync (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .next_state   (next_state),
        .mismatch     (mismatch),
        .expected     (expected),
        .in_sync      (in_sync),
        .byte_err     (byte_err),
        .count_enable (count_enable)
    );

    prbs_err_counter u_count (
        .clk          (clk),
        .reset        (reset),
        .count_enable (count_enable),
        .clear_count  (clear_count),
        .err_count    (err_count)
    );

    // Status bundle
    assign status = '{in_sync: in_sync, byte_err: byte_err, err_count: err_count};

endmodule

`default_nettype wire

// File: testbench/prbs_mon_asserts.sv
/* Concurrent checks on the monitor top, attached by bind. */
`timescale 1ns/1ps
`default_nettype none

module prbs_mon_asserts import prbs_pkg::*; (
    input wire logic       clk,
    input wire logic       reset,
    input wire rx_byte_t   rx,
    input wire logic       clear_count,
    input wire rx_status_t status
);

    // Error pulse only after a valid byte
    err_needs_byte: assert property (@(posedge clk) disable iff (reset)
        status.byte_err |-> $past(rx.valid))
        else $error("byte_err without a valid byte one cycle earlier");

    // Count only drops after a clear
    count_no_drop: assert property (@(posedge clk) disable iff (reset)
        (status.err_count < $past(status.err_count)) |-> $past(clear_count))
        else $error("err_count decreased without clear_count");

    // Hunt out of reset
    hunt_after_reset: assert property (@(posedge clk)
        reset |=> !status.in_sync)
        else $error("in_sync high after reset");

endmodule

bind prbs_mon_top prbs_mon_asserts asserts_i (
    .clk         (clk),
    .reset       (reset),
    .rx          (rx),
    .clear_count (clear_count),
    .status      (status)
);

`default_nettype wire

// File: testbench/prbs_mon_tb.sv
/* Testbench for the PRBS15 pattern subsystem. Runs the segments of the vectors
   file, checks tx and status every cycle against a reference model. */
`timescale 1ns/1ps
`default_nettype none

module prbs_mon_tb import prbs_pkg::*; ();

    localparam int max_cycles = 20000;
    localparam int vec_words  = 5;

    logic       clk;
    logic       reset;
    logic       tx_enable;
    logic       inject_error;
    logic       clear_count;
    tx_byte_t   tx;
    rx_byte_t   rx;
    rx_status_t status;

    // Segment table, five words per line
    logic [15:0] vec_mem [0:255];

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;
    // Loopback of tx into rx, and the tx byte seen last cycle
    logic        loop_on;
    tx_byte_t    tx_seen;

    // Reference model state
    prbs_state_t m_gen;
    logic        m_pend;
    logic        m_tx_valid;
    byte_t       m_tx_data;
    prbs_state_t m_exp;
    logic        m_lock;
    int          m_run;
    logic        m_be;
    logic        m_cen;
    err_count_t  m_count;

    prbs_mon_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .tx_enable    (tx_enable),
        .inject_error (inject_error),
        .tx           (tx),
        .rx           (rx),
        .clear_count  (clear_count),
        .status       (status)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random positions and the PRBS reference

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'ha300_0000;
        end
        return lsb;
    endfunction

    function automatic int pick_pos(input int range);
        int v;
        v = 0;
        for (int i = 0; i < 8; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return 1 + (v % range);
    endfunction

    // Eight new bits, each tap 15 xor tap 14, first bit in the MSB
    function automatic byte_t ref_prbs_byte(inout prbs_state_t st);
        byte_t b;
        logic  nb;
        for (int i = 7; i >= 0; i--) begin
            nb   = st[14] ^ st[13];
            b[i] = nb;
            st   = {st[13:0], nb};
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Model step for the inputs the DUT takes at the next edge

    task automatic model_step(input logic en, input logic inj, input rx_byte_t r,
                              input logic clr);
        logic        mm;
        logic        pred;
        prbs_state_t st;
        m_tx_valid = en;
        if (en) begin
            m_tx_data = ref_prbs_byte(m_gen) ^ byte_t'(inj | m_pend);
            m_pend    = 1'b0;
        end else if (inj) begin
            m_pend = 1'b1;
        end
        // Counter sees last cycle's pulse
        if (clr) begin
            m_count = '0;
        end else if (m_cen && m_count != 16'hffff) begin
            m_count = m_count + 1'b1;
        end
        mm = 1'b0;
        if (r.valid) begin
            st = m_exp;
            mm = (st == '0);
            for (int i = 7; i >= 0; i--) begin
                pred = st[14] ^ st[13];
                if (r.data[i] != pred) begin
                    mm = 1'b1;
                end
                st = {st[13:0], r.data[i]};
            end
            m_exp = st;
        end
        m_cen = mm & m_lock;
        m_be  = mm;
        if (r.valid) begin
            if (!m_lock) begin
                m_run = mm ? 0 : m_run + 1;
                if (m_run == 4) begin
                    m_lock = 1'b1;
                    m_run  = 0;
                end
            end else begin
                m_run = mm ? m_run + 1 : 0;
                if (m_run == 3) begin
                    m_lock = 1'b0;
                    m_run  = 0;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_status(input rx_status_t got, input rx_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail status got 0x%h expected 0x%h (in_sync %h/%h byte_err %h/%h)",
                     got, exp, got.in_sync, exp.in_sync, got.byte_err, exp.byte_err);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One clock cycle of stimulus and checking

    task automatic drive_cycle(input logic en, input logic inj, input rx_byte_t src,
                               input byte_t corrupt, input logic clr);
        rx_byte_t r;
        @(posedge clk);
        r = loop_on ? rx_byte_t'(tx_seen) : src;
        if (r.valid) begin
            r.data = r.data ^ corrupt;
        end
        tx_enable    <= en;
        inject_error <= inj;
        rx           <= r;
        clear_count  <= clr;
        @(negedge clk);
        // Outputs here reflect inputs of the previous cycle
        check_bit("tx.valid", tx.valid, m_tx_valid);
        if (m_tx_valid) begin
            check_byte("tx.data", tx.data, m_tx_data);
        end
        check_status(status, '{in_sync: m_lock, byte_err: m_be, err_count: m_count});
        tx_seen = tx;
        model_step(en, inj, r, clr);
    endtask

    // Idle until tx and rx have been quiet for a few cycles
    task automatic settle();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 3 && waited < 20) begin
            drive_cycle(1'b0, 1'b0, '0, '0, 1'b0);
            if (!tx.valid && !rx.valid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            waited++;
        end
        if (quiet < 3) begin
            errors++;
            $display("Status did not settle within 20 idle cycles after a segment");
        end
    endtask

    task automatic run_segment(input int mode, input int count, input byte_t mask,
                               input logic exp_sync, input err_count_t exp_cnt);
        int         pos;
        err_count_t cnt;
        case (mode)
            0: begin
                // Transmit only, optional inject pulse
                loop_on = 1'b0;
                pos     = pick_pos(count - 2);
                for (int i = 0; i < count; i++) begin
                    drive_cycle(1'b1, mask[0] && i == pos, '0, '0, 1'b0);
                end
            end
            1: begin
                loop_on = 1'b1;
                for (int i = 0; i < count; i++) begin
                    drive_cycle(1'b1, 1'b0, '0, '0, 1'b0);
                end
            end
            2: begin
                // Loopback with one corrupted byte
                // Looped bytes reach rx from the third cycle on
                loop_on = 1'b1;
                pos     = 1 + pick_pos(count - 8);
                for (int i = 0; i < count; i++) begin
                    drive_cycle(1'b1, 1'b0, '0, (i == pos) ? mask : 8'h00, 1'b0);
                end
            end
            3: begin
                loop_on = 1'b0;
                for (int i = 0; i < count; i++) begin
                    drive_cycle(1'b0, 1'b0, '{valid: 1'b1, data: 8'h00}, '0, 1'b0);
                end
            end
            4: begin
                loop_on = 1'b0;
                for (int i = 0; i < count; i++) begin
                    drive_cycle(1'b0, 1'b0, '0, '0, i == 0);
                end
            end
            default: begin
                errors++;
                $display("Unknown segment mode %0d in the vectors file", mode);
            end
        endcase
        settle();
        // All ones in the count column means the model count is used
        cnt = (exp_cnt == 16'hffff) ? m_count : exp_cnt;
        check_status(status, '{in_sync: exp_sync, byte_err: 1'b0, err_count: cnt});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int idx;
        clk          = 1'b0;
        reset        = 1'b1;
        tx_enable    = 1'b0;
        inject_error = 1'b0;
        clear_count  = 1'b0;
        rx           = '0;
        errors       = 0;
        checks       = 0;
        lfsr_state   = 32'h3ede;
        loop_on      = 1'b0;
        tx_seen      = '0;
        m_gen        = '1;
        m_pend       = 1'b0;
        m_tx_valid   = 1'b0;
        m_tx_data    = '0;
        m_exp        = '0;
        m_lock       = 1'b0;
        m_run        = 0;
        m_be         = 1'b0;
        m_cen        = 1'b0;
        m_count      = '0;
        $readmemh("testbench/prbs_mon_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        idx = 0;
        while (idx < 250 && vec_mem[idx] !== 16'h000f) begin
            if ($isunknown(vec_mem[idx])) begin
                errors++;
                $display("Vectors file has no end marker at word %0d", idx);
                break;
            end
            run_segment(vec_mem[idx], vec_mem[idx+1], vec_mem[idx+2][7:0],
                        vec_mem[idx+3][0], vec_mem[idx+4]);
            idx += vec_words;
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (max_cycles) @(posedge clk);
        $display("Simulation ran past %0d cycles without finishing", max_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/prbs_mon_vectors.txt
// Columns: mode count mask in_sync err_count (hex)
// Modes: 0 tx only, 1 loopback, 2 loopback with corrupted byte, 3 zero bytes,
// 4 clear; count ffff means the model count is used; mode f ends the table
// Transmit pattern against the model
0 0028 00 0 0000
// Single inject_error pulse
0 0014 01 0 0000
// Loopback, hunt then lock
1 001e 00 1 0000
// Last bit flipped, bad byte and one later window
2 0014 01 1 0002
// First bit flipped, two bad bytes in a row
2 0014 80 1 0004
// Two flips, three bad bytes, lock lost and regained
2 0014 81 1 0007
// Zero bytes drop the lock
3 0006 00 0 ffff
// Clear the count
4 0004 00 0 0000
// Resync from the zero state
1 0014 00 1 0000
// Count resumes from zero
2 0014 01 1 0002
f 0000 00 0 0000

// File: sources.f
design/prbs_pkg.sv
design/prbs_gen.sv
design/prbs_check.sv
design/prbs_sync_fsm.sv
design/prbs_err_counter.sv
design/prbs_mon_top.sv
testbench/prbs_mon_asserts.sv
testbench/prbs_mon_tb.sv

// File: Bender.yml
package:
  name: prbs_mon

sources:
  - files:
      - design/prbs_pkg.sv
      - design/prbs_gen.sv
      - design/prbs_check.sv
      - design/prbs_sync_fsm.sv
      - design/prbs_err_counter.sv
      - design/prbs_mon_top.sv
  - target: test
    files:
      - testbench/prbs_mon_asserts.sv
      - testbench/prbs_mon_tb.sv
